/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ----------------------------------------------------------------------
// Core dimensions
// ----------------------------------------------------------------------

// Register and operand width
`define DATA_W 16

// Flags register, x86 layout up to OF
`define FLAGS_W 12

`define QUEUE_DEPTH 4   // Decoded instructions in flight between stages

`define NUM_REGS 8      // AX CX DX BX SP BP SI DI

`endif

/* cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    // ------------------------------------------------------------------
    // ALU operations, same order as opcode bits 5:3
    // ------------------------------------------------------------------
    typedef enum logic [2:0] {
        opAdd = 3'd0,
        opOr  = 3'd1,
        opAdc = 3'd2,
        opSbb = 3'd3,
        opAnd = 3'd4,
        opSub = 3'd5,
        opXor = 3'd6,
        opCmp = 3'd7
    } aluOp;

    // Instruction classes handled by the execution unit
    typedef enum logic [2:0] {
        kAluImm = 3'd0,     // ALU AL/AX, imm
        kMovImm = 3'd1,     // MOV reg, imm
        kIncDec = 3'd2,     // INC/DEC r16
        kFlagOp = 3'd3,     // CMC CLC STC
        kNop    = 3'd4
    } instrKind;

    typedef enum logic [1:0] {
        fCmc = 2'd0,
        fClc = 2'd1,
        fStc = 2'd2
    } flagCmd;

    // One decoded instruction, 28 bits
    typedef struct packed {
        instrKind           kind;
        aluOp               op;
        flagCmd             cmd;
        logic [2:0]         regIdx;
        logic               wide;       // 1 = 16 bit
        logic [`DATA_W-1:0] imm;
    } decodedInstr;

    // Flag bit positions
    localparam int CF = 0;
    localparam int PF = 2;
    localparam int AF = 4;
    localparam int ZF = 6;
    localparam int SF = 7;
    localparam int OF = 11;

endpackage

/* instr_assembler.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module instr_assembler import cpu_pkg::*; (
    input  logic        clk25,
    input  logic        reset,
    input  logic        byteValid,
    input  logic [7:0]  byteData,
    output logic        byteReady,
    output logic        instValid,
    output decodedInstr instData,
    input  logic        instReady
);

    logic [1:0]  remain;        // Immediate bytes still due
    decodedInstr pend;          // Record being collected
    decodedInstr decoded;       // Opcode decode of byteData
    logic [1:0]  needBytes;
    logic        byteTake;
    logic        emit;
    decodedInstr emitData;

    // Stall only while the finished record is stuck
    assign byteReady = !instValid || instReady;
    assign byteTake  = byteValid && byteReady;

    // ------------------------------------------------------------------
    // Opcode decode
    // ------------------------------------------------------------------
    always_comb begin
        decoded      = '0;
        decoded.kind = kNop;    // Unknown opcodes retire as NOP
        needBytes    = 2'd0;
        casez (byteData)
            8'b00??_?10?: begin     // ALU AL/AX, imm
                decoded.kind = kAluImm;
                decoded.op   = aluOp'(byteData[5:3]);
                decoded.wide = byteData[0];
                needBytes    = byteData[0] ? 2'd2 : 2'd1;
            end
            8'b1011_????: begin     // MOV reg, imm
                decoded.kind   = kMovImm;
                decoded.wide   = byteData[3];
                decoded.regIdx = byteData[2:0];
                needBytes      = byteData[3] ? 2'd2 : 2'd1;
            end
            8'b0100_????: begin     // INC/DEC r16
                decoded.kind   = kIncDec;
                decoded.op     = byteData[3] ? opSub : opAdd;
                decoded.wide   = 1'b1;
                decoded.regIdx = byteData[2:0];
                decoded.imm    = `DATA_W'(1);
            end
            8'hF5: begin            // CMC
                decoded.kind = kFlagOp;
                decoded.cmd  = fCmc;
            end
            8'hF8: begin
                decoded.kind = kFlagOp;
                decoded.cmd  = fClc;
            end
            8'hF9: begin
                decoded.kind = kFlagOp;
                decoded.cmd  = fStc;
            end
            default: ;
        endcase
    end

    // Record completed by the byte taken this cycle
    always_comb begin
        emitData = pend;
        emit     = 1'b0;
        if (byteTake) begin
            if (remain == 2'd0) begin
                emitData = decoded;
                emit     = (needBytes == 2'd0);
            end else if (remain == 2'd1) begin
                emit = 1'b1;
                if (pend.wide)
                    emitData.imm[15:8] = byteData;
                else
                    emitData.imm = {8'h00, byteData};   // High byte stays zero
            end
        end
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            remain    <= 2'd0;
            instValid <= 1'b0;
        end else begin
            if (byteTake)
                remain <= (remain == 2'd0) ? needBytes : remain - 2'd1;
            if (emit)
                instValid <= 1'b1;
            else if (instReady)
                instValid <= 1'b0;
        end
    end

    // Payload path
    always_ff @(posedge clk25) begin
        if (byteTake) begin
            if (remain == 2'd0)
                pend <= decoded;
            else if (remain == 2'd2)
                pend.imm[7:0] <= byteData;  // Low byte comes first
        end
        if (emit)
            instData <= emitData;
    end

endmodule

/* instr_queue.sv */
`timescale 1ns/10ps

module instr_queue import cpu_pkg::*; #(
    parameter type elemType = logic [7:0],
    parameter int  depth    = 4
) (
    input  logic    clk25,
    input  logic    reset,
    input  logic    inValid,
    input  elemType inData,
    output logic    inReady,
    output logic    outValid,
    output elemType outData,
    input  logic    outReady
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    elemType         mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;     // Occupancy
    logic            doWrite;
    logic            doRead;

    assign inReady  = (count != cntW'(depth));
    assign outValid = (count != '0);
    assign outData  = mem[rdPtr];
    assign doWrite  = inValid && inReady;
    assign doRead   = outValid && outReady;

    always_ff @(posedge clk25) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite)
                wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
            if (doRead)
                rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk25) begin
        if (doWrite)
            mem[wrPtr] <= inData;
    end

endmodule

/* alu.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
    input  aluOp                op,
    input  logic                wide,
    input  logic [`DATA_W-1:0]  a,
    input  logic [`DATA_W-1:0]  b,
    input  logic [`FLAGS_W-1:0] flagsIn,
    output logic [`DATA_W-1:0]  result,
    output logic [`FLAGS_W-1:0] flagsOut
);

    logic [`DATA_W-1:0] aw;     // Operands cut to the selected width
    logic [`DATA_W-1:0] bw;
    logic [`DATA_W:0]   r;      // One extra bit for carry or borrow
    logic               cin;
    logic               aSign;
    logic               bSign;
    logic               rSign;
    logic               isAdd;
    logic               isSub;

    assign aw    = wide ? a : {8'h00, a[7:0]};
    assign bw    = wide ? b : {8'h00, b[7:0]};
    assign cin   = flagsIn[CF];
    assign aSign = wide ? aw[15] : aw[7];
    assign bSign = wide ? bw[15] : bw[7];
    assign rSign = wide ? r[15] : r[7];
    assign isAdd = (op == opAdd) || (op == opAdc);
    assign isSub = (op == opSub) || (op == opSbb) || (op == opCmp);

    always_comb begin
        case (op)
            opAdd:   r = {1'b0, aw} + {1'b0, bw};
            opOr:    r = {1'b0, aw | bw};
            opAdc:   r = {1'b0, aw} + {1'b0, bw} + {16'h0000, cin};
            opSbb:   r = {1'b0, aw} - {1'b0, bw} - {16'h0000, cin};
            opAnd:   r = {1'b0, aw & bw};
            opXor:   r = {1'b0, aw ^ bw};
            default: r = {1'b0, aw} - {1'b0, bw};  // SUB, CMP
        endcase
    end

    assign result = wide ? r[15:0] : {8'h00, r[7:0]};

    // ------------------------------------------------------------------
    // Flag generation
    // ------------------------------------------------------------------
    always_comb begin
        flagsOut       = '0;
        flagsOut[10:8] = flagsIn[10:8];     // TF IF DF untouched
        flagsOut[1]    = 1'b1;
        flagsOut[SF]   = rSign;
        flagsOut[ZF]   = wide ? (r[15:0] == 16'h0000) : (r[7:0] == 8'h00);
        flagsOut[PF]   = ~^r[7:0];          // Even parity, low byte only
        if (isAdd || isSub) begin
            flagsOut[CF] = wide ? r[16] : r[8];
            flagsOut[AF] = aw[4] ^ bw[4] ^ r[4];    // Carry/borrow at bit 4
        end else begin
            flagsOut[AF] = r[4];
        end
        if (isAdd)
            flagsOut[OF] = (aSign == bSign) && (rSign != aSign);
        else if (isSub)
            flagsOut[OF] = (aSign != bSign) && (rSign != aSign);
    end

endmodule

/* exec_unit.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module exec_unit import cpu_pkg::*; (
    input  logic                clk25,
    input  logic                reset,
    input  logic                headValid,
    input  decodedInstr         headData,
    output logic                headReady,
    output logic                retireValid,
    output logic [2:0]          retireReg,
    output logic                retireWide,
    output logic                retireWrite,
    output logic [`DATA_W-1:0]  retireValue,
    output logic [`FLAGS_W-1:0] retireFlags,
    input  logic                retireReady
);

    logic [`DATA_W-1:0]  regFile [`NUM_REGS];
    logic [`FLAGS_W-1:0] flags;
    logic                accept;
    logic [2:0]          lowIdx;    // AX..BX for byte access
    logic [`DATA_W-1:0]  readVal;
    logic [`DATA_W-1:0]  aluResult;
    logic [`FLAGS_W-1:0] aluFlags;
    logic                writeEn;
    logic [`DATA_W-1:0]  writeVal;
    logic [`FLAGS_W-1:0] nextFlags;

    assign headReady = !retireValid || retireReady;
    assign accept    = headValid && headReady;
    assign lowIdx    = {1'b0, headData.regIdx[1:0]};

    // Byte index 4..7 reads the high half of AX..BX
    assign readVal = headData.wide      ? regFile[headData.regIdx] :
                     headData.regIdx[2] ? {8'h00, regFile[lowIdx][15:8]} :
                                          {8'h00, regFile[lowIdx][7:0]};

    alu alu_i (
        .op       (headData.op),
        .wide     (headData.wide),
        .a        (readVal),
        .b        (headData.imm),
        .flagsIn  (flags),
        .result   (aluResult),
        .flagsOut (aluFlags)
    );

    // ------------------------------------------------------------------
    // Per-instruction effect
    // ------------------------------------------------------------------
    always_comb begin
        writeEn   = 1'b0;
        writeVal  = aluResult;
        nextFlags = flags;
        case (headData.kind)
            kAluImm: begin
                writeEn   = (headData.op != opCmp);
                nextFlags = aluFlags;
            end
            kIncDec: begin
                writeEn   = 1'b1;
                nextFlags = aluFlags;
            end
            kMovImm: begin
                writeEn  = 1'b1;
                writeVal = headData.imm;
            end
            kFlagOp: begin
                case (headData.cmd)
                    fCmc:    nextFlags[CF] = ~flags[CF];
                    fClc:    nextFlags[CF] = 1'b0;
                    default: nextFlags[CF] = 1'b1;
                endcase
            end
            default: ;  // NOP
        endcase
    end

    always_ff @(posedge clk25) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regFile[i] <= '0;
            flags       <= '0;
            retireValid <= 1'b0;
        end else if (accept) begin
            flags       <= nextFlags;
            retireValid <= 1'b1;
            if (writeEn) begin
                if (headData.wide)
                    regFile[headData.regIdx] <= writeVal;
                else if (headData.regIdx[2])
                    regFile[lowIdx][15:8] <= writeVal[7:0];    // AH..BH
                else
                    regFile[lowIdx][7:0] <= writeVal[7:0];     // AL..BL
            end
        end else if (retireReady) begin
            retireValid <= 1'b0;
        end
    end

    // Retire record
    always_ff @(posedge clk25) begin
        if (accept) begin
            retireReg   <= headData.regIdx;
            retireWide  <= headData.wide;
            retireWrite <= writeEn;
            retireValue <= headData.wide ? writeVal : {8'h00, writeVal[7:0]};
            retireFlags <= nextFlags;
        end
    end

endmodule

/* cpu_core.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_core import cpu_pkg::*; (
    input  logic                clk25,
    input  logic                reset,
    input  logic                byteValid,
    input  logic [7:0]          byteData,
    output logic                byteReady,
    output logic                retireValid,
    output logic [2:0]          retireReg,
    output logic                retireWide,
    output logic                retireWrite,
    output logic [`DATA_W-1:0]  retireValue,
    output logic [`FLAGS_W-1:0] retireFlags,
    input  logic                retireReady
);

    // Assembler to queue
    logic        instValid;
    decodedInstr instData;
    logic        instReady;

    // Queue to execution unit
    logic        headValid;
    decodedInstr headData;
    logic        headReady;

    instr_assembler assembler_i (
        .clk25     (clk25),
        .reset     (reset),
        .byteValid (byteValid),
        .byteData  (byteData),
        .byteReady (byteReady),
        .instValid (instValid),
        .instData  (instData),
        .instReady (instReady)
    );

    instr_queue #(
        .elemType (decodedInstr),
        .depth    (`QUEUE_DEPTH)
    ) queue_i (
        .clk25    (clk25),
        .reset    (reset),
        .inValid  (instValid),
        .inData   (instData),
        .inReady  (instReady),
        .outValid (headValid),
        .outData  (headData),
        .outReady (headReady)
    );

    exec_unit exec_i (
        .clk25       (clk25),
        .reset       (reset),
        .headValid   (headValid),
        .headData    (headData),
        .headReady   (headReady),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireWide  (retireWide),
        .retireWrite (retireWrite),
        .retireValue (retireValue),
        .retireFlags (retireFlags),
        .retireReady (retireReady)
    );

endmodule

/* cpu_assert.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_assert import cpu_pkg::*; (
    input logic                clk25,
    input logic                reset,
    input logic                byteValid,
    input logic [7:0]          byteData,
    input logic                byteReady,
    input logic                instValid,
    input decodedInstr         instData,
    input logic                instReady,
    input logic                headValid,
    input decodedInstr         headData,
    input logic                headReady,
    input logic                retireValid,
    input logic [2:0]          retireReg,
    input logic                retireWide,
    input logic                retireWrite,
    input logic [`DATA_W-1:0]  retireValue,
    input logic [`FLAGS_W-1:0] retireFlags,
    input logic                retireReady
);

    int occupancy;  // Queue fill level seen from its two handshakes

    always_ff @(posedge clk25) begin
        if (reset)
            occupancy <= 0;
        else
            occupancy <= occupancy + int'(instValid && instReady)
                                   - int'(headValid && headReady);
    end

    // ------------------------------------------------------------------
    // Valid held with stable payload until the transfer
    // ------------------------------------------------------------------
    byteHold: assert property (@(posedge clk25) disable iff (reset)
        byteValid && !byteReady |=> byteValid && $stable(byteData))
        else $error("byte stream changed before its transfer");

    instHold: assert property (@(posedge clk25) disable iff (reset)
        instValid && !instReady |=> instValid && $stable(instData))
        else $error("assembler record changed before its transfer");

    headHold: assert property (@(posedge clk25) disable iff (reset)
        headValid && !headReady |=> headValid && $stable(headData))
        else $error("queue head changed before its transfer");

    retireHold: assert property (@(posedge clk25) disable iff (reset)
        retireValid && !retireReady |=> retireValid &&
        $stable({retireReg, retireWide, retireWrite, retireValue, retireFlags}))
        else $error("retire record changed before its transfer");

    retireAfterReset: assert property (@(posedge clk25) reset |=> !retireValid)
        else $error("retireValid high right after reset");

    // Full queue must refuse writes
    queueFull: assert property (@(posedge clk25) disable iff (reset)
        !(instReady && occupancy == `QUEUE_DEPTH))
        else $error("instReady high while the queue is full");

    byteStall: assert property (@(posedge clk25) disable iff (reset)
        instValid && !instReady |-> !byteReady)
        else $error("byteReady high while a record is stuck");

endmodule

/* cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;

    localparam int          totalInstr    = 400;
    localparam int          timeoutCycles = totalInstr * 3 * 8 + 200;
    localparam logic [31:0] seed          = 32'hb977_cbab;

    logic        clk25;
    logic        reset;
    logic        byteValid;
    logic [7:0]  byteData;
    logic        byteReady;
    logic        retireValid;
    logic [2:0]  retireReg;
    logic        retireWide;
    logic        retireWrite;
    logic [15:0] retireValue;
    logic [11:0] retireFlags;
    logic        retireReady;

    logic [15:0] mReg [8];      // Reference register file
    logic [11:0] mFlags;
    logic [32:0] expQ [$];      // {reg, wide, write, value, flags}
    logic [31:0] stimState;
    logic [31:0] stallState;
    int          sentCount;
    int          retiredCount;
    int          cycles;

    cpu_core dut_i (
        .clk25       (clk25),
        .reset       (reset),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .byteReady   (byteReady),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireWide  (retireWide),
        .retireWrite (retireWrite),
        .retireValue (retireValue),
        .retireFlags (retireFlags),
        .retireReady (retireReady)
    );

    bind cpu_core cpu_assert assert_i (
        .clk25       (clk25),
        .reset       (reset),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .byteReady   (byteReady),
        .instValid   (instValid),
        .instData    (instData),
        .instReady   (instReady),
        .headValid   (headValid),
        .headData    (headData),
        .headReady   (headReady),
        .retireValid (retireValid),
        .retireReg   (retireReg),
        .retireWide  (retireWide),
        .retireWrite (retireWrite),
        .retireValue (retireValue),
        .retireFlags (retireFlags),
        .retireReady (retireReady)
    );

    initial begin
        clk25 = 1'b0;
        forever #5 clk25 = ~clk25;
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] randWord();
        stimState = lcgStep(stimState);
        return stimState[31:16];
    endfunction

    // Opcodes 04/05, 0C/0D ... 3C/3D
    function automatic logic isAluImm(input logic [7:0] opc);
        return (opc <= 8'h3D) && (opc[2:0] == 3'd4 || opc[2:0] == 3'd5);
    endfunction

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic [27:0] aluRef(input logic [2:0] op, input logic wide,
                                           input logic [15:0] a, input logic [15:0] b,
                                           input logic [11:0] fIn);
        int          mask;
        int          ua;
        int          ub;
        int          sa;
        int          sb;
        int          sr;
        int          full;
        int          cin;
        logic        arith;
        logic [15:0] res;
        logic [11:0] f;
        mask  = wide ? 32'h0000_FFFF : 32'h0000_00FF;
        ua    = int'(a) & mask;
        ub    = int'(b) & mask;
        sa    = (ua > mask / 2) ? ua - mask - 1 : ua;  // Signed view at width
        sb    = (ub > mask / 2) ? ub - mask - 1 : ub;
        cin   = ((op == 3'd2 || op == 3'd3) && fIn[0]) ? 1 : 0;
        f     = 12'h002 | (fIn & 12'h700);
        arith = 1'b1;
        sr    = 0;
        if (op == 3'd0 || op == 3'd2) begin
            full  = ua + ub + cin;
            sr    = sa + sb + cin;
            f[0]  = (full > mask);
            f[4]  = ((ua & 15) + (ub & 15) + cin) > 15;
        end else if (op == 3'd3 || op == 3'd5 || op == 3'd7) begin
            full  = ua - ub - cin;
            sr    = sa - sb - cin;
            f[0]  = (full < 0);     // Borrow
            f[4]  = (ua & 15) < ((ub & 15) + cin);
        end else begin
            arith = 1'b0;
            full  = (op == 3'd1) ? (ua | ub) : (op == 3'd4) ? (ua & ub) : (ua ^ ub);
        end
        res = 16'(full & mask);
        if (arith)
            f[11] = (sr > mask / 2) || (sr < -(mask / 2) - 1);
        else
            f[4] = res[4];
        f[6] = (res == 16'h0000);
        f[7] = wide ? res[15] : res[7];
        f[2] = ($countones(res[7:0]) % 2) == 0;
        return {res, f};
    endfunction

    function automatic logic [32:0] refExecute(input logic [7:0] opc, input logic [15:0] imm);
        logic [2:0]  idx;
        logic        wide;
        logic        write;
        logic [15:0] a;
        logic [15:0] res;
        logic [11:0] f;
        idx   = 3'd0;
        wide  = 1'b0;
        write = 1'b0;
        res   = 16'h0000;
        f     = mFlags;
        if (isAluImm(opc)) begin
            wide     = opc[0];
            a        = wide ? mReg[0] : {8'h00, mReg[0][7:0]};
            {res, f} = aluRef(opc[5:3], wide, a, imm, mFlags);
            write    = (opc[5:3] != 3'd7);     // CMP leaves AL/AX alone
        end else if (opc[7:4] == 4'h4) begin
            idx      = opc[2:0];
            wide     = 1'b1;
            write    = 1'b1;
            {res, f} = aluRef(opc[3] ? 3'd5 : 3'd0, 1'b1, mReg[idx], 16'h0001, mFlags);
        end else if (opc[7:4] == 4'hB) begin
            idx   = opc[2:0];
            wide  = opc[3];
            write = 1'b1;
            res   = wide ? imm : {8'h00, imm[7:0]};
        end else begin
            case (opc)
                8'hF5:   f[0] = ~f[0];  // CMC
                8'hF8:   f[0] = 1'b0;
                8'hF9:   f[0] = 1'b1;
                default: ;              // NOP or unknown opcode
            endcase
        end
        if (write) begin
            if (wide)
                mReg[idx] = res;
            else if (idx[2])
                mReg[{1'b0, idx[1:0]}][15:8] = res[7:0];   // AH..BH
            else
                mReg[{1'b0, idx[1:0]}][7:0] = res[7:0];
        end
        mFlags = f;
        return {idx, wide, write, write ? res : 16'h0000, f};
    endfunction

    task automatic abortRun();
        $display("Test failures found");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic checkField(input string name, input logic [15:0] expVal,
                              input logic [15:0] actVal);
        assert (actVal === expVal)
        else begin
            $display("Error: %0t ns %s expected %h actual %h", $time, name, expVal, actVal);
            abortRun();
        end
    endtask

    // ------------------------------------------------------------------
    // Byte stream driver
    // ------------------------------------------------------------------
    task automatic sendByte(input logic [7:0] b);
        stimState = lcgStep(stimState);
        if (stimState[31:30] == 2'b00)
            repeat (int'(stimState[29:28]) + 1) @(negedge clk25);   // Idle gap
        byteValid = 1'b1;
        byteData  = b;
        while (!byteReady)
            @(negedge clk25);
        @(negedge clk25);   // Taken on the edge in between
        byteValid = 1'b0;
    endtask

    task automatic sendInstr(input logic [7:0] opc, input logic [15:0] imm);
        int nImm;
        nImm = 0;
        if (isAluImm(opc))
            nImm = opc[0] ? 2 : 1;
        else if (opc[7:4] == 4'hB)
            nImm = opc[3] ? 2 : 1;
        expQ.push_back(refExecute(opc, imm));
        sentCount++;
        sendByte(opc);
        if (nImm > 0)
            sendByte(imm[7:0]);
        if (nImm > 1)
            sendByte(imm[15:8]);
    endtask

    initial begin : stimulus
        logic [7:0] opc;
        logic [3:0] sel;
        logic [3:0] opr;
        reset        = 1'b1;
        byteValid    = 1'b0;
        byteData     = 8'h00;
        stimState    = seed;
        stallState   = ~seed;
        sentCount    = 0;
        retiredCount = 0;
        mFlags       = 12'h000;
        for (int i = 0; i < 8; i++)
            mReg[i] = 16'h0000;
        repeat (5) @(negedge clk25);
        reset = 1'b0;

        sendInstr(8'h05, randWord());       // ADD AX from the reset state
        for (int i = 0; i < 8; i++) begin
            sendInstr(8'hB8 | 8'(i), randWord());
            sendInstr(8'hB0 | 8'(i), randWord());
        end
        sendInstr(8'h0D, 16'h0000);         // OR AX,0 shows AH:AL
        for (int i = 0; i < 8; i++) begin
            sendInstr(8'h40 | 8'(i), 16'h0000);
            sendInstr(8'h48 | 8'(i), 16'h0000);
            sendInstr(8'hB8 | 8'(i), 16'hFFFF);
            sendInstr(8'h40 | 8'(i), 16'h0000);   // Wraps to 0000
            sendInstr(8'h48 | 8'(i), 16'h0000);   // Back to FFFF
        end
        for (int op = 0; op < 16; op++)
            sendInstr({2'b00, 3'(op >> 1), 2'b10, 1'(op)}, randWord());

        // Random mix
        while (sentCount < totalInstr) begin
            stimState = lcgStep(stimState);
            sel       = stimState[31:28];
            opr       = stimState[27:24];
            if (sel < 4'd6)
                opc = {2'b00, opr[2:0], 2'b10, opr[3]};
            else if (sel < 4'd9)
                opc = {4'hB, opr};
            else if (sel < 4'd12)
                opc = {4'h4, opr};
            else if (opr[1:0] == 2'd0)
                opc = 8'hF5;
            else if (opr[1:0] == 2'd1)
                opc = 8'hF8;
            else if (opr[1:0] == 2'd2)
                opc = 8'hF9;
            else
                opc = opr[2] ? 8'h90 : 8'hF4;   // F4 falls back to NOP
            sendInstr(opc, randWord());
        end

        while (retiredCount < sentCount)
            @(negedge clk25);
        repeat (20) @(negedge clk25);   // Catch any extra retire
        if (retiredCount == sentCount && expQ.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Retired %0d instructions but sent %0d", retiredCount, sentCount);
            abortRun();
        end
    end

    // Retire stalls and the compare of each accepted record
    initial begin : retireCompare
        logic [32:0] exp;
        int          stallBurst;    // Cycles left in a long stall
        retireReady = 1'b0;
        stallBurst  = 0;
        forever begin
            @(negedge clk25);
            stallState = lcgStep(stallState);
            if (stallBurst > 0)
                stallBurst--;
            else if (stallState[29:25] == 5'd0)
                stallBurst = 16 + int'(stallState[24:22]);  // Backs up into the byte stream
            retireReady = (stallBurst == 0) && (stallState[31:30] != 2'b00);
            if (!reset && retireValid && retireReady) begin
                assert (expQ.size() > 0)
                else begin
                    $display("Retire at %0t ns with no instruction outstanding", $time);
                    abortRun();
                end
                exp = expQ.pop_front();
                checkField("retireReg", 16'(exp[32:30]), 16'(retireReg));
                checkField("retireWide", 16'(exp[29]), 16'(retireWide));
                checkField("retireWrite", 16'(exp[28]), 16'(retireWrite));
                checkField("retireFlags", 16'(exp[11:0]), 16'(retireFlags));
                if (exp[28])
                    checkField("retireValue", exp[27:12], retireValue);
                retiredCount++;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        forever begin
            @(posedge clk25);
            cycles++;
            if (cycles >= timeoutCycles) begin
                $display("Timeout: retires stopped after %0d of %0d instructions",
                         retiredCount, sentCount);
                abortRun();
            end
        end
    end

endmodule

/* build.f */
+incdir+.
cpu_pkg.sv
instr_assembler.sv
instr_queue.sv
alu.sv
exec_unit.sv
cpu_core.sv
cpu_assert.sv
cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the CPU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -f build.f -o cpu_sim > "$BUILD_LOG" 2>&1
buildStatus=$?
cat "$BUILD_LOG"
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/cpu_sim > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"

# The log decides the result
if grep -q "Test failures found" "$SIM_LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
